// File: compile.f
+incdir+rtl
rtl/mul_pkg.sv
rtl/radix4_unit.sv
rtl/wallace_33bit.sv
rtl/booth_mul.sv
rtl/mul_op_ctrl.sv
rtl/mul_unit.sv
verification/mul_unit_tb.sv

// File: Makefile
.PHONY: sim clean

sim:
	verilator --binary --assert --top-module mul_unit_tb -f compile.f -o mul_unit_sim
	./obj_dir/mul_unit_sim > sim.log 2>&1 ; status=$$? ; cat sim.log ; test $$status -eq 0
	! grep -q "=== FAIL ===" sim.log

clean:
	rm -rf obj_dir sim.log

// File: verification/mul_unit_tb.sv
`timescale 1ns/1ps

module mul_unit_tb;

    ////////////////////////////////////////////////////////////
    // run sizes

    localparam int TAB_N  = 20;
    localparam int RAND_N = 200;
    // two cycles per op plus margin for reset and drain
    localparam int LIMIT  = (TAB_N + RAND_N) * 2 + 50;

    // edge operands
    localparam mul_pkg::xlen_t ONES = 64'hffffffffffffffff;
    localparam mul_pkg::xlen_t MINV = 64'h8000000000000000;
    localparam mul_pkg::xlen_t MAXV = 64'h7fffffffffffffff;

    // one directed vector
    typedef struct packed {
        mul_pkg::mul_op_e op;
        mul_pkg::xlen_t   rs1;
        mul_pkg::xlen_t   rs2;
        mul_pkg::xlen_t   want;
    } vec_t;

    // op, rs1, rs2, expected result
    localparam vec_t TAB [TAB_N] = '{
        // mul low half, edge values
        '{mul_pkg::MUL,    64'h0, ONES, 64'h0},
        '{mul_pkg::MUL,    64'h1, ONES, ONES},
        '{mul_pkg::MUL,    ONES, ONES, 64'h1},
        '{mul_pkg::MUL,    MINV, 64'h2, 64'h0},
        '{mul_pkg::MUL,    MAXV, MAXV, 64'h1},
        '{mul_pkg::MUL,    MINV, ONES, MINV},
        // high halves, sign handling differs per op
        '{mul_pkg::MULH,   ONES, ONES, 64'h0},
        '{mul_pkg::MULH,   MINV, MINV, 64'h4000000000000000},
        '{mul_pkg::MULH,   64'hfffffffffffffffe, 64'h3, ONES},
        '{mul_pkg::MULH,   MAXV, MINV, 64'hc000000000000000},
        '{mul_pkg::MULHSU, ONES, ONES, ONES},
        '{mul_pkg::MULHSU, MINV, MINV, 64'hc000000000000000},
        '{mul_pkg::MULHSU, 64'h2, ONES, 64'h1},
        '{mul_pkg::MULHU,  ONES, ONES, 64'hfffffffffffffffe},
        '{mul_pkg::MULHU,  MINV, 64'h2, 64'h1},
        '{mul_pkg::MULHU,  MAXV, MAXV, 64'h3fffffffffffffff},
        // word ops, upper halves are junk
        '{mul_pkg::MULW,   64'hdeadbeef00000003, 64'h1234567800000005, 64'h000000000000000f},
        '{mul_pkg::MULW,   64'h000000007fffffff, 64'hffffffff00000002, 64'hfffffffffffffffe},
        '{mul_pkg::MULW,   64'haaaaaaaaffffffff, 64'h55555555ffffffff, 64'h1},
        '{mul_pkg::MULW,   64'h1234567880000000, 64'h9abcdef080000000, 64'h0}
    };

    logic               clk;
    logic               rst;
    mul_pkg::mul_req_t  req;
    mul_pkg::mul_rsp_t  rsp;

    // scoreboard
    mul_pkg::xlen_t want_q [$];
    int             cyc_q  [$];
    int             cycles;
    int             val_errs;
    int             time_errs;

    // driver and monitor scratch
    logic [15:0]      lfsr;
    int               i;
    mul_pkg::mul_op_e op;
    mul_pkg::xlen_t   a;
    mul_pkg::xlen_t   b;
    mul_pkg::xlen_t   bits;
    mul_pkg::xlen_t   want;
    mul_pkg::xlen_t   want_m;
    int               issue_m;

    mul_unit dut (
        .clk (clk),
        .rst (rst),
        .req (req),
        .rsp (rsp)
    );

    ////////////////////////////////////////////////////////////
    // random source

    // x^16 + x^14 + x^13 + x^11 + 1
    function automatic logic [15:0] lfsr_next(input logic [15:0] s);
        return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};
    endfunction

    // one step per bit taken
    task automatic take_bits(input int n, output mul_pkg::xlen_t v);
        v = '0;
        for (int k = 0; k < n; k++) begin
            lfsr = lfsr_next(lfsr);
            v    = {v[62:0], lfsr[0]};
        end
    endtask

    // expected result from 128 bit arithmetic
    function automatic mul_pkg::xlen_t ref_result(input mul_pkg::mul_op_e rop,
                                                  input mul_pkg::xlen_t ra,
                                                  input mul_pkg::xlen_t rb);
        logic signed [127:0] sa;
        logic signed [127:0] sb;
        logic signed [127:0] ua;
        logic signed [127:0] ub;
        logic signed [127:0] wa;
        logic signed [127:0] wb;
        logic [127:0]        p;
        mul_pkg::xlen_t      r;
        sa = {{64{ra[63]}}, ra};
        sb = {{64{rb[63]}}, rb};
        ua = {64'h0, ra};
        ub = {64'h0, rb};
        wa = {{96{ra[31]}}, ra[31:0]};
        wb = {{96{rb[31]}}, rb[31:0]};
        case (rop)
            mul_pkg::MULH: begin
                p = sa * sb;
                r = p[127:64];
            end
            mul_pkg::MULHSU: begin
                p = sa * ub;
                r = p[127:64];
            end
            mul_pkg::MULHU: begin
                p = ua * ub;
                r = p[127:64];
            end
            mul_pkg::MULW: begin
                p = wa * wb;
                r = {{32{p[31]}}, p[31:0]};
            end
            default: begin
                p = ua * ub;
                r = p[63:0];
            end
        endcase
        return r;
    endfunction

    ////////////////////////////////////////////////////////////
    // clock and cycle limit

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    always @(posedge clk) begin
        cycles = cycles + 1;
        if (cycles >= LIMIT) begin
            $display("timeout: responses still missing after %0d cycles", LIMIT);
            $display("=== FAIL ===");
            $finish;
        end
    end

    ////////////////////////////////////////////////////////////
    // response monitor, mid cycle so outputs are settled

    always @(negedge clk) begin
        if (!rst && $isunknown(rsp.valid)) begin
            $display("response valid is unknown in cycle %0d", cycles);
            time_errs++;
        end
        // a response two cycles late counts as lost
        if (want_q.size() != 0 && cyc_q[0] + 2 < cycles) begin
            $display("no response for the request of cycle %0d", cyc_q[0]);
            time_errs++;
            void'(want_q.pop_front());
            void'(cyc_q.pop_front());
        end
        if (!rst && rsp.valid === 1'b1) begin
            if (want_q.size() == 0) begin
                $display("response in cycle %0d with no request pending", cycles);
                time_errs++;
            end else begin
                want_m  = want_q.pop_front();
                issue_m = cyc_q.pop_front();
                if (cycles != issue_m + 2) begin
                    $display("response latency %0d cycles, expected 2", cycles - issue_m);
                    time_errs++;
                end
                if (rsp.result !== want_m) begin
                    $display("error rsp.result expected %h actual %h", want_m, rsp.result);
                    val_errs++;
                end
            end
        end
    end

    ////////////////////////////////////////////////////////////
    // stimulus

    initial begin
        rst       = 1'b1;
        req       = '0;
        lfsr      = 16'd2573;
        cycles    = 0;
        val_errs  = 0;
        time_errs = 0;
        repeat (2) @(posedge clk);
        #1;
        rst = 1'b0;

        // directed table, then random ops, no gaps
        for (i = 0; i < TAB_N + RAND_N; i++) begin
            if (i < TAB_N) begin
                op   = TAB[i].op;
                a    = TAB[i].rs1;
                b    = TAB[i].rs2;
                want = TAB[i].want;
            end else begin
                take_bits(3, bits);
                op = mul_pkg::mul_op_e'(bits[2:0] % 3'd5);
                take_bits(64, a);
                take_bits(64, b);
                want = ref_result(op, a, b);
            end
            req.valid = 1'b1;
            req.op    = op;
            req.rs1   = a;
            req.rs2   = b;
            want_q.push_back(want);
            cyc_q.push_back(cycles);
            @(posedge clk);
            #1;
        end
        req = '0;

        // drain, then a few idle cycles for stray responses
        while (want_q.size() != 0) begin
            @(posedge clk);
        end
        repeat (3) @(negedge clk);

        $display("errors: %0d value, %0d timing", val_errs, time_errs);
        if (val_errs + time_errs == 0) begin
            $display("=== PASS ===");
        end else begin
            $display("=== FAIL ===");
        end
        $finish;
    end

endmodule

// File: rtl/mul_unit.sv
`timescale 1ns/1ps

// integer multiply unit
// one op per cycle, result two cycles after the request
module mul_unit (
    input  logic               clk,
    input  logic               rst,
    input  mul_pkg::mul_req_t  req,
    output mul_pkg::mul_rsp_t  rsp
);

    ////////////////////////////////////////////////////////////
    // ctrl to core

    // decoded operands
    mul_pkg::mul_opnd_t opnd;

    // product back from the core
    mul_pkg::prod_t prod;
    logic           prod_valid;

    ////////////////////////////////////////////////////////////
    // decode, op tracking and result select
    mul_op_ctrl u_ctrl (
        .clk        (clk),
        .rst        (rst),
        .req        (req),
        .opnd       (opnd),
        .prod       (prod),
        .prod_valid (prod_valid),
        .rsp        (rsp)
    );

    ////////////////////////////////////////////////////////////
    // booth core
    booth_mul u_core (
        .clk        (clk),
        .rst        (rst),
        .opnd       (opnd),
        .prod       (prod),
        .prod_valid (prod_valid)
    );

endmodule

// File: rtl/mul_op_ctrl.sv
`timescale 1ns/1ps
`include "mul_defs.svh"

// operation decode in front of the core, result select behind it
module mul_op_ctrl (
    input  logic                clk,
    input  logic                rst,
    input  mul_pkg::mul_req_t   req,
    output mul_pkg::mul_opnd_t  opnd,
    input  mul_pkg::prod_t      prod,
    input  logic                prod_valid,
    output mul_pkg::mul_rsp_t   rsp
);

    // word half used by mulw
    localparam int HW = `MUL_XLEN / 2;

    // valid tracking, stage 0 lines up with prod, stage 1 with rsp
    logic [1:0]       v_pipe;
    // op of the product now in the core
    mul_pkg::mul_op_e op_r;

    // result select
    mul_pkg::xlen_t sel;
    mul_pkg::xlen_t result_r;

    ////////////////////////////////////////////////////////////
    // front decode, no register
    always_comb begin
        opnd.valid = req.valid;
        if (req.op == mul_pkg::MULW) begin
            // word op, upper operand halves ignored
            opnd.a      = {{HW{req.rs1[HW-1]}}, req.rs1[HW-1:0]};
            opnd.b      = {{HW{req.rs2[HW-1]}}, req.rs2[HW-1:0]};
            opnd.sign_a = 1'b1;
            opnd.sign_b = 1'b1;
        end else begin
            opnd.a      = req.rs1;
            opnd.b      = req.rs2;
            // mul low half is sign independent, treat as signed
            opnd.sign_a = (req.op == mul_pkg::MUL) || (req.op == mul_pkg::MULH)
                          || (req.op == mul_pkg::MULHSU);
            opnd.sign_b = (req.op == mul_pkg::MUL) || (req.op == mul_pkg::MULH);
        end
    end

    ////////////////////////////////////////////////////////////
    // op pipeline alongside the core
    always_ff @(posedge clk) begin
        if (rst) begin
            v_pipe <= '0;
            op_r   <= mul_pkg::MUL;
        end else begin
            v_pipe <= {v_pipe[0], req.valid};
            op_r   <= req.op;
        end
    end

    ////////////////////////////////////////////////////////////
    // back end, pick the word
    always_comb begin
        case (op_r)
            mul_pkg::MULH,
            mul_pkg::MULHSU,
            mul_pkg::MULHU: sel = prod[2*`MUL_XLEN-1:`MUL_XLEN];
            mul_pkg::MULW:  sel = {{HW{prod[HW-1]}}, prod[HW-1:0]};
            default:        sel = prod[`MUL_XLEN-1:0];
        endcase
    end

    // result word, held between products
    always_ff @(posedge clk) begin
        if (rst) begin
            result_r <= '0;
        end else if (prod_valid) begin
            result_r <= sel;
        end
    end

    assign rsp = '{valid: v_pipe[1], result: result_r};

    // core latency matches the op pipeline
    a_core_aligned : assert property (@(posedge clk) disable iff (rst)
        prod_valid == v_pipe[0]);

    a_legal_op : assert property (@(posedge clk) disable iff (rst)
        req.valid |-> req.op inside {mul_pkg::MUL, mul_pkg::MULH, mul_pkg::MULHSU,
                                     mul_pkg::MULHU, mul_pkg::MULW});

endmodule

// File: rtl/booth_mul.sv
`timescale 1ns/1ps
`include "mul_defs.svh"

// radix-4 booth multiplier, wallace reduction, one register stage
// prod_valid follows opnd.valid by one cycle
module booth_mul (
    input  logic                clk,
    input  logic                rst,
    input  mul_pkg::mul_opnd_t  opnd,
    output mul_pkg::prod_t      prod,
    output logic                prod_valid
);

    // lateral carries per column
    localparam int CW = 30;

    // operand extension
    logic               ext_a;
    logic               ext_b;
    logic [`MUL_XLEN+2:0] mplier;
    logic [`MUL_PW-1:0] mcand;

    // booth rows and transposed columns
    logic [`MUL_PW-1:0]   row_pp [`MUL_ROWS];
    logic [`MUL_ROWS-1:0] row_neg;
    logic [`MUL_ROWS-1:0] col_bits [`MUL_PW];
    logic [CW-1:0]        col_carry [`MUL_PW];

    // carry-save result of the tree
    logic [`MUL_PW-1:0] sum_vec;
    logic [`MUL_PW-1:0] carry_vec;

    // stage register
    logic [`MUL_PW-1:0] sum_r;
    logic [`MUL_PW-1:0] carry_r;
    logic               ci_r;

    ////////////////////////////////////////////////////////////
    // operand prep

    // top bit only counts as sign when the op says so
    assign ext_a = opnd.a[`MUL_XLEN-1] & opnd.sign_a;
    assign ext_b = opnd.b[`MUL_XLEN-1] & opnd.sign_b;

    // booth windows read a with an implicit zero below bit 0
    // two extension bits so an unsigned a stays positive
    assign mplier = {ext_a, ext_a, opnd.a, 1'b0};

    // multiplicand widened to the full internal width
    assign mcand = {{(`MUL_PW-`MUL_XLEN){ext_b}}, opnd.b};

    ////////////////////////////////////////////////////////////
    // booth rows, then transpose into columns
    for (genvar i = 0; i < `MUL_ROWS; i++) begin : g_row
        radix4_unit u_row (
            .win   (mplier[2*i +: 3]),
            .mcand (mcand << (2*i)),
            .pp    (row_pp[i]),
            .neg   (row_neg[i])
        );
        for (genvar j = 0; j < `MUL_PW; j++) begin : g_tr
            assign col_bits[j][i] = row_pp[i][j];
        end
    end

    ////////////////////////////////////////////////////////////
    // wallace columns

    // column 0 has no neighbour on the right
    // its carry inputs take the row negate bits instead
    assign col_carry[0]  = row_neg[CW-1:0];
    assign carry_vec[0]  = row_neg[CW];

    for (genvar j = 0; j < `MUL_PW; j++) begin : g_col
        if (j < `MUL_PW - 1) begin : g_mid
            wallace_33bit u_col (
                .n    (col_bits[j]),
                .cin  (col_carry[j]),
                .cout (col_carry[j+1]),
                .s    (sum_vec[j]),
                .c    (carry_vec[j+1])
            );
        end else begin : g_top
            // carries out of the top column fall past the product
            wallace_33bit u_col (
                .n    (col_bits[j]),
                .cin  (col_carry[j]),
                .cout (),
                .s    (sum_vec[j]),
                .c    ()
            );
        end
    end

    ////////////////////////////////////////////////////////////
    // stage register and final add
    always_ff @(posedge clk) begin
        if (rst) begin
            prod_valid <= 1'b0;
            sum_r      <= '0;
            carry_r    <= '0;
            ci_r       <= 1'b0;
        end else begin
            prod_valid <= opnd.valid;
            sum_r      <= sum_vec;
            carry_r    <= carry_vec;
            // spare negate bit, joins as adder carry in
            // top window is pure extension, its row never negates
            ci_r       <= row_neg[CW+1];
        end
    end

    // carry-propagate add, truncated to the full product
    assign prod = mul_pkg::prod_t'(sum_r + carry_r + {{(`MUL_PW-1){1'b0}}, ci_r});

    // control output stays clean out of reset
    a_valid_known : assert property (@(posedge clk) disable iff (rst)
        !$isunknown(prod_valid));

endmodule

// File: rtl/wallace_33bit.sv
`timescale 1ns/1ps

// one wallace column, 33 bits down to a sum and a carry
// lateral carries leave at level k and enter the next column at level k+1
module wallace_33bit (
    input  logic [32:0] n,
    input  logic [29:0] cin,
    output logic [29:0] cout,
    output logic        s,
    output logic        c
);

    // level sums and level inputs
    logic [10:0] l1_s;
    logic [21:0] l2_in;
    logic [6:0]  l2_s;
    logic [14:0] l3_in;
    logic [4:0]  l3_s;
    logic [9:0]  l4_in;
    logic [2:0]  l4_s;
    logic [6:0]  l5_in;
    logic [1:0]  l5_s;
    logic [4:0]  l6_in;
    logic        l6_s;
    logic [3:0]  l7_in;
    logic        l7_s;

    // full adder, returns {carry, sum}
    function automatic logic [1:0] fa(input logic x, input logic y, input logic z);
        return {(x & y) | (x & z) | (y & z), x ^ y ^ z};
    endfunction

    ////////////////////////////////////////////////////////////
    // level 1: 33 partial bits, 11 adders
    for (genvar k = 0; k < 11; k++) begin : g_l1
        assign {cout[k], l1_s[k]} = fa(n[3*k], n[3*k+1], n[3*k+2]);
    end

    // level 2: 11 sums plus 11 carries, 7 adders, one bit passes
    assign l2_in = {cin[10:0], l1_s};
    for (genvar k = 0; k < 7; k++) begin : g_l2
        assign {cout[11+k], l2_s[k]} = fa(l2_in[3*k], l2_in[3*k+1], l2_in[3*k+2]);
    end

    // level 3: 15 bits, 5 adders
    assign l3_in = {cin[17:11], l2_in[21], l2_s};
    for (genvar k = 0; k < 5; k++) begin : g_l3
        assign {cout[18+k], l3_s[k]} = fa(l3_in[3*k], l3_in[3*k+1], l3_in[3*k+2]);
    end

    // level 4: 10 bits, 3 adders, one bit passes
    assign l4_in = {cin[22:18], l3_s};
    for (genvar k = 0; k < 3; k++) begin : g_l4
        assign {cout[23+k], l4_s[k]} = fa(l4_in[3*k], l4_in[3*k+1], l4_in[3*k+2]);
    end

    // level 5: 7 bits, 2 adders
    assign l5_in = {cin[25:23], l4_in[9], l4_s};
    for (genvar k = 0; k < 2; k++) begin : g_l5
        assign {cout[26+k], l5_s[k]} = fa(l5_in[3*k], l5_in[3*k+1], l5_in[3*k+2]);
    end

    ////////////////////////////////////////////////////////////
    // tail levels, one adder each

    // level 6: 5 bits
    assign l6_in = {cin[27:26], l5_in[6], l5_s};
    assign {cout[28], l6_s} = fa(l6_in[0], l6_in[1], l6_in[2]);

    // level 7: 4 bits
    assign l7_in = {cin[28], l6_in[4:3], l6_s};
    assign {cout[29], l7_s} = fa(l7_in[0], l7_in[1], l7_in[2]);

    // last adder, carry belongs to the next column's carry vector
    assign {c, s} = fa(l7_in[3], l7_s, cin[29]);

endmodule

// File: rtl/radix4_unit.sv
`timescale 1ns/1ps
`include "mul_defs.svh"

// one radix-4 booth row
// window bits are {b[2i+1], b[2i], b[2i-1]}
module radix4_unit (
    input  logic [2:0]         win,
    input  logic [`MUL_PW-1:0] mcand,
    output logic [`MUL_PW-1:0] pp,
    output logic               neg
);

    // row magnitude select
    logic               sel_one;
    logic               sel_two;
    logic [`MUL_PW-1:0] mag;

    // 001 010 101 110 pick one times the multiplicand
    assign sel_one = win[1] ^ win[0];

    // 011 and 100 pick two times
    assign sel_two = (win == 3'b011) || (win == 3'b100);

    always_comb begin
        if (sel_one) begin
            mag = mcand;
        end else if (sel_two) begin
            mag = mcand << 1;
        end else begin
            // 000 and 111 give a zero row
            mag = '0;
        end
    end

    // negative windows, except 111 which is zero
    assign neg = win[2] & ~(win[1] & win[0]);

    // one's complement here
    // the +1 goes into the tree as a separate bit
    assign pp = neg ? ~mag : mag;

endmodule

// File: rtl/mul_pkg.sv
`include "mul_defs.svh"

package mul_pkg;

    ////////////////////////////////////////////////////////////
    // data words
    ////////////////////////////////////////////////////////////

    // one register word
    typedef logic [`MUL_XLEN-1:0] xlen_t;

    // full double-width product
    typedef logic [2*`MUL_XLEN-1:0] prod_t;

    // M extension multiply ops
    typedef enum logic [2:0] {
        MUL    = 3'd0,
        MULH   = 3'd1,
        MULHSU = 3'd2,
        MULHU  = 3'd3,
        MULW   = 3'd4
    } mul_op_e;

    ////////////////////////////////////////////////////////////
    // pipeline bundles
    ////////////////////////////////////////////////////////////

    // request from the execute stage
    typedef struct packed {
        logic    valid;
        mul_op_e op;
        xlen_t   rs1;
        xlen_t   rs2;
    } mul_req_t;

    // decoded operands into the booth core
    typedef struct packed {
        logic  valid;
        xlen_t a;
        xlen_t b;
        logic  sign_a;
        logic  sign_b;
    } mul_opnd_t;

    // result back to the execute stage
    typedef struct packed {
        logic  valid;
        xlen_t result;
    } mul_rsp_t;

endpackage

// File: rtl/mul_defs.svh
`ifndef MUL_DEFS_SVH
`define MUL_DEFS_SVH

////////////////////////////////////////////////////////////
// multiply unit sizes
////////////////////////////////////////////////////////////

// operand width, one integer register
`define MUL_XLEN 64

// radix-4 booth rows
// (xlen + 2) / 2, the extra row covers unsigned operands
`define MUL_ROWS 33

// internal product width before truncation
// two rows of headroom over the full product
`define MUL_PW 132

`endif
